// ==== rvfi_mon_params.svh ====
`ifndef RVFI_MON_PARAMS_SVH
`define RVFI_MON_PARAMS_SVH

// retirement record widths
`define RVFI_XLEN       32      // data and pc width
`define RVFI_ORDER_W    32      // order number width

// error log
`define ERR_CNT_W       16      // retired and error counters, saturating

// axi4-lite slave
`define AXIL_AW         5       // byte address, 8 words mapped

// register map, byte offsets
`define REG_STATUS      5'h00   // sticky check flags
`define REG_RETIRED     5'h04   // valid records seen
`define REG_ERRORS      5'h08   // records with any flag set
`define REG_FIRST_FAIL  5'h0C   // order of first flagged record
`define REG_CTRL        5'h10   // bit 0 write clears the log

`endif

// ==== rvfi_mon_pkg.sv ====
package rvfi_mon_pkg;
`include "rvfi_mon_params.svh"

	// one retired instruction as seen on the rvfi port
	typedef struct packed {
		logic                     valid;      // record present this cycle
		logic [`RVFI_ORDER_W-1:0] order;      // program order index
		logic [31:0]              insn;       // instruction word
		logic                     trap;       // no architectural effect
		logic                     halt;       // last instruction before a restart
		logic [4:0]               rs1_addr;
		logic [4:0]               rs2_addr;
		logic [`RVFI_XLEN-1:0]    rs1_rdata;  // rs1 value before the insn
		logic [`RVFI_XLEN-1:0]    rs2_rdata;
		logic [4:0]               rd_addr;
		logic [`RVFI_XLEN-1:0]    rd_wdata;   // rd value after the insn
		logic [`RVFI_XLEN-1:0]    pc_rdata;   // pc of this insn
		logic [`RVFI_XLEN-1:0]    pc_wdata;   // pc of the next insn
	} rvfi_retire_t;

	// bit 0 is pc_err so the struct maps straight onto the status word
	typedef struct packed {
		logic x0_err;       // bit 3
		logic reg_err;      // bit 2
		logic order_err;    // bit 1
		logic pc_err;       // bit 0
	} check_flags_t;

	typedef struct packed {
		logic                     valid;  // one cycle after the retire cycle
		check_flags_t             flags;
		logic [`RVFI_ORDER_W-1:0] order;  // order of the checked record
	} check_result_t;

	typedef struct packed {
		logic                awvalid;
		logic [`AXIL_AW-1:0] awaddr;
		logic                wvalid;
		logic [31:0]         wdata;
		logic [3:0]          wstrb;
		logic                bready;
		logic                arvalid;
		logic [`AXIL_AW-1:0] araddr;
		logic                rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

// ==== rvfi_pc_check.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_pc_check import rvfi_mon_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  rvfi_retire_t  retire,
	output check_result_t result
);

	logic [`RVFI_XLEN-1:0]    next_pc;      // pc_wdata of previous record
	logic [`RVFI_ORDER_W-1:0] last_order;   // order of previous record
	logic                     base_valid;   // previous record is a usable baseline
	logic                     pc_bad;
	logic                     order_bad;

	assign pc_bad    = retire.pc_rdata != next_pc;
	assign order_bad = retire.order != (last_order + 1'b1);

	// baseline and result are control state
	always_ff @(posedge clk) begin
		if (reset) begin
			base_valid <= 1'b0;     // first record after reset starts a baseline
			result     <= '0;
		end else begin
			result.valid <= retire.valid;
			result.order <= retire.order;
			result.flags <= '0;     // pulse, one cycle per record
			if (retire.valid) begin
				if (base_valid) begin
					result.flags.pc_err    <= pc_bad;
					result.flags.order_err <= order_bad;
				end
				base_valid <= !retire.halt;  // record after a halt is a new baseline
			end
		end
	end

	// trapping records still move the pc and order forward
	always_ff @(posedge clk) begin
		if (retire.valid) begin
			next_pc    <= retire.pc_wdata;
			last_order <= retire.order;
		end
	end

endmodule

// ==== rvfi_reg_check.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_reg_check import rvfi_mon_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  rvfi_retire_t  retire,
	output check_result_t result
);

	logic [`RVFI_XLEN-1:0] shadow [1:31];   // copy of x1..x31
	logic [31:1]           written;         // entry holds a value seen since reset
	logic                  rs1_bad;
	logic                  rs2_bad;
	logic                  x0_bad;
	logic                  checked;         // record is subject to register checks
	logic                  rd_update;

	// x0 must read zero, other regs only once the shadow knows them
	function automatic logic src_mismatch(
		input logic [4:0]            addr,
		input logic [`RVFI_XLEN-1:0] data
	);
		logic mismatch;
		if (addr == 5'd0)
			mismatch = (data != '0);
		else
			mismatch = written[addr] && (shadow[addr] != data);
		return mismatch;
	endfunction

	always_comb begin
		rs1_bad = src_mismatch(retire.rs1_addr, retire.rs1_rdata);
		rs2_bad = src_mismatch(retire.rs2_addr, retire.rs2_rdata);
	end

	assign x0_bad    = (retire.rd_addr == 5'd0) && (retire.rd_wdata != '0);
	assign checked   = retire.valid && !retire.trap;          // traps are skipped here
	assign rd_update = checked && (retire.rd_addr != 5'd0);   // x0 is never stored

	always_ff @(posedge clk) begin
		if (reset) begin
			written <= '0;          // no register known after reset
			result  <= '0;
		end else begin
			result.valid           <= retire.valid;
			result.order           <= retire.order;
			result.flags.pc_err    <= 1'b0;    // continuity belongs to the pc checker
			result.flags.order_err <= 1'b0;
			result.flags.reg_err   <= checked && (rs1_bad || rs2_bad);
			result.flags.x0_err    <= checked && x0_bad;
			if (rd_update)
				written[retire.rd_addr] <= 1'b1;
		end
	end

	// sources compare against the value before this record's own write
	always_ff @(posedge clk) begin
		if (rd_update)
			shadow[retire.rd_addr] <= retire.rd_wdata;
	end

endmodule

// ==== rvfi_err_log.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_err_log import rvfi_mon_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     clear,
	input  check_flags_t             flags,
	input  logic                     flags_valid,
	input  logic [`RVFI_ORDER_W-1:0] flags_order,
	output check_flags_t             status,
	output logic [`ERR_CNT_W-1:0]    retired,
	output logic [`ERR_CNT_W-1:0]    errors,
	output logic [`RVFI_ORDER_W-1:0] first_fail
);

	logic any_err;      // record carries at least one flag
	logic first_hit;    // first flagged record since reset or clear
	logic ret_full;
	logic err_full;

	assign any_err   = flags_valid && (flags != '0);
	assign first_hit = any_err && (status == '0);   // empty status means nothing logged yet
	assign ret_full  = &retired;
	assign err_full  = &errors;

	always_ff @(posedge clk) begin
		if (reset || clear) begin   // clear beats a record in the same cycle
			status     <= '0;
			retired    <= '0;
			errors     <= '0;
			first_fail <= '0;
		end else if (flags_valid) begin
			status <= status | flags;                   // sticky
			if (!ret_full)
				retired <= retired + 1'b1;              // saturates at all ones
			if (any_err && !err_full)
				errors <= errors + 1'b1;                // once per record, not per flag
			if (first_hit)
				first_fail <= flags_order;
		end
	end

endmodule

// ==== rvfi_axil_regs.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_axil_regs import rvfi_mon_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  axil_req_t                axil_req,
	output axil_rsp_t                axil_rsp,
	input  check_flags_t             status,
	input  logic [`ERR_CNT_W-1:0]    retired,
	input  logic [`ERR_CNT_W-1:0]    errors,
	input  logic [`RVFI_ORDER_W-1:0] first_fail,
	output logic                     clear
);

	logic                wr_go;     // aw and w handshake this cycle
	logic                rd_go;     // ar handshake this cycle
	logic                bvalid;
	logic                rvalid;
	logic [31:0]         rdata;     // held while rvalid waits for rready
	logic [31:0]         rd_word;   // decoded read value
	logic [`AXIL_AW-1:0] wr_addr;   // word aligned offsets
	logic [`AXIL_AW-1:0] rd_addr;
	logic                ctrl_hit;  // write sets the clear bit

	// aw and w are taken together, only with no response pending
	assign wr_go    = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_go    = axil_req.arvalid && !rvalid;
	assign wr_addr  = {axil_req.awaddr[`AXIL_AW-1:2], 2'b00};
	assign rd_addr  = {axil_req.araddr[`AXIL_AW-1:2], 2'b00};
	assign ctrl_hit = (wr_addr == `REG_CTRL) && axil_req.wstrb[0] && axil_req.wdata[0];

	// write channel and clear pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
			clear  <= 1'b0;
		end else begin
			clear <= wr_go && ctrl_hit;     // single cycle, self clearing
			if (wr_go)
				bvalid <= 1'b1;             // response on the next cycle
			else if (axil_req.bready)
				bvalid <= 1'b0;             // held until accepted
		end
	end

	// read channel
	always_ff @(posedge clk) begin
		if (reset)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (axil_req.rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_go)
			rdata <= rd_word;   // frozen until the next accepted address
	end

	// register map, unmapped and ctrl read back as zero
	always_comb begin
		rd_word = '0;
		case (rd_addr)
			`REG_STATUS:     rd_word[3:0] = status;
			`REG_RETIRED:    rd_word[`ERR_CNT_W-1:0] = retired;
			`REG_ERRORS:     rd_word[`ERR_CNT_W-1:0] = errors;
			`REG_FIRST_FAIL: rd_word = first_fail;
			default:         rd_word = '0;
		endcase
	end

	always_comb begin
		axil_rsp.awready = wr_go;
		axil_rsp.wready  = wr_go;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.bresp   = 2'b00;   // always okay
		axil_rsp.arready = rd_go;
		axil_rsp.rvalid  = rvalid;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = 2'b00;   // okay, unmapped included
	end

endmodule

// ==== rvfi_mon_top.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_mon_top import rvfi_mon_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  rvfi_retire_t retire,
	input  axil_req_t    axil_req,
	output axil_rsp_t    axil_rsp
);

	check_result_t            pc_res;       // continuity checks
	check_result_t            reg_res;      // register checks
	check_flags_t             flags;        // merged one cycle pulse
	logic                     flags_valid;
	check_flags_t             status;
	logic [`ERR_CNT_W-1:0]    retired;
	logic [`ERR_CNT_W-1:0]    errors;
	logic [`RVFI_ORDER_W-1:0] first_fail;
	logic                     clear;

	// both checkers register in the same cycle, so the results line up
	assign flags       = pc_res.flags | reg_res.flags;
	assign flags_valid = pc_res.valid | reg_res.valid;

	rvfi_pc_check pc_chk0 (
		.clk        (clk),
		.reset      (reset),
		.retire     (retire),
		.result     (pc_res)
	);

	rvfi_reg_check reg_chk0 (
		.clk        (clk),
		.reset      (reset),
		.retire     (retire),
		.result     (reg_res)
	);

	rvfi_err_log err_log0 (
		.clk         (clk),
		.reset       (reset),
		.clear       (clear),
		.flags       (flags),
		.flags_valid (flags_valid),
		.flags_order (pc_res.order),
		.status      (status),
		.retired     (retired),
		.errors      (errors),
		.first_fail  (first_fail)
	);

	rvfi_axil_regs axil_regs0 (
		.clk        (clk),
		.reset      (reset),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.status     (status),
		.retired    (retired),
		.errors     (errors),
		.first_fail (first_fail),
		.clear      (clear)
	);

endmodule

// ==== rvfi_mon_sva.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_mon_sva import rvfi_mon_pkg::*; (
	input logic                  clk,
	input logic                  reset,
	input axil_req_t             axil_req,
	input axil_rsp_t             axil_rsp,
	input logic [`ERR_CNT_W-1:0] retired,
	input logic [`ERR_CNT_W-1:0] errors
);

	int fails = 0;      // failed assertion count

	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
	else begin
		$error("bvalid dropped before bready");
		fails++;
	end

	// data must not move while the master stalls
	a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
	else begin
		$error("read response changed before rready");
		fails++;
	end

	// read data follows the address handshake by one cycle
	a_read_next: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.arready |=> axil_rsp.rvalid)
	else begin
		$error("no read response after the address handshake");
		fails++;
	end

	a_reset_state: assert property (@(posedge clk)
		reset |=> !axil_rsp.bvalid && !axil_rsp.rvalid && retired == '0 && errors == '0)
	else begin
		$error("outputs or counters not cleared by reset");
		fails++;
	end

endmodule

bind rvfi_mon_top rvfi_mon_sva sva0 (
	.clk      (clk),
	.reset    (reset),
	.axil_req (axil_req),
	.axil_rsp (axil_rsp),
	.retired  (retired),
	.errors   (errors)
);

// ==== rvfi_mon_tb.sv ====
`timescale 1ns/100ps
`include "rvfi_mon_params.svh"

module rvfi_mon_tb import rvfi_mon_pkg::*; ();

	localparam int TMO = 50;        // cycles allowed for any handshake

	typedef struct packed {
		logic [2:0] grp;            // test the row belongs to
		logic       pc_jmp;         // break pc continuity
		logic       ord_skip;       // skip one order number
		logic       halt;
		logic       trap;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic       bad_rs;         // rs1 data off from the shadow copy
		logic [4:0] rd;
		logic       x0_bad;         // nonzero write to x0
		logic [3:0] flags;          // expected {x0, reg, order, pc}
	} row_t;

	logic         clk;
	logic         reset;
	rvfi_retire_t retire;
	axil_req_t    axil_req;
	axil_rsp_t    axil_rsp;
	row_t         tbl[$];
	logic [31:0]  m_pc;             // next pc the model expects
	logic [31:0]  m_ord;            // next order the model expects
	logic [31:0]  m_reg [32];       // model of the shadow registers
	logic         m_known [32];
	logic [3:0]   e_status;
	int           e_retired;
	int           e_errors;
	logic [31:0]  e_first;
	logic         e_caught;         // first_fail already latched
	int           errs;
	int           test_errs;
	int           tests;
	int           tests_failed;

	rvfi_mon_top dut0 (.clk(clk), .reset(reset), .retire(retire),
		.axil_req(axil_req), .axil_rsp(axil_rsp));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;      // 8 ns period
	end

	task automatic add_row(input logic [2:0] grp, input logic pc_jmp, ord_skip, halt, trap,
		input logic [4:0] rs1, rs2, input logic bad_rs, input logic [4:0] rd,
		input logic x0_bad, input logic [3:0] flags);
		tbl.push_back({grp, pc_jmp, ord_skip, halt, trap, rs1, rs2, bad_rs, rd, x0_bad, flags});
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
			test_errs++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// x0 reads zero, unknown regs get any value
	function automatic logic [31:0] src_value(input logic [4:0] a);
		if (a == 5'd0)
			return 32'h0;
		return m_known[a] ? m_reg[a] : $urandom;
	endfunction

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
		int n;
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		axil_req.wstrb   <= 4'hf;
		axil_req.bready  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!axil_rsp.awready && n < TMO);
		if (!axil_rsp.awready)
			abort_run("awready never rose");
		check_eq(axil_rsp.wready, 1'b1, "wready with awready");
		@(posedge clk);             // aw and w taken here
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!axil_rsp.bvalid && n < TMO);
		if (!axil_rsp.bvalid)
			abort_run("no write response");
		check_eq(axil_rsp.bresp, 2'b00, "bresp");
		@(posedge clk);             // b taken here
		axil_req.bready <= 1'b0;
	endtask

	// hold > 0 keeps rready low that many cycles after rvalid
	task automatic axi_read(input logic [4:0] addr, input int hold, output logic [31:0] data);
		int n;
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		axil_req.rready  <= (hold == 0);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!axil_rsp.arready && n < TMO);
		if (!axil_rsp.arready)
			abort_run("arready never rose");
		@(posedge clk);
		axil_req.arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!axil_rsp.rvalid && n < TMO);
		if (!axil_rsp.rvalid)
			abort_run("no read data");
		data = axil_rsp.rdata;
		check_eq(axil_rsp.rresp, 2'b00, "rresp");
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			check_eq(axil_rsp.rvalid, 1'b1, "rvalid under back-pressure");
			check_eq(axil_rsp.rdata, data, "rdata under back-pressure");
		end
		if (hold > 0) begin
			@(posedge clk);
			axil_req.rready <= 1'b1;
		end
		@(posedge clk);             // r taken here
		axil_req.rready <= 1'b0;
	endtask

	task automatic check_regs();
		logic [31:0] d;
		axi_read(`REG_STATUS, 0, d);
		check_eq(d, {28'h0, e_status}, "status");
		axi_read(`REG_RETIRED, 0, d);
		check_eq(d, e_retired, "retired");
		axi_read(`REG_ERRORS, 0, d);
		check_eq(d, e_errors, "errors");
		axi_read(`REG_FIRST_FAIL, 0, d);
		check_eq(d, e_first, "first_fail");
	endtask

	task automatic apply_group(input int g);
		rvfi_retire_t rec;
		row_t         r;
		foreach (tbl[i]) begin
			r = tbl[i];
			if (r.grp == g) begin
				rec           = '0;
				rec.valid     = 1'b1;
				rec.insn      = $urandom;
				rec.pc_rdata  = r.pc_jmp ? m_pc + 32'h100 : m_pc;
				rec.pc_wdata  = rec.pc_rdata + 32'd4;
				rec.order     = r.ord_skip ? m_ord + 1 : m_ord;
				rec.trap      = r.trap;
				rec.halt      = r.halt;
				rec.rs1_addr  = r.rs1;
				rec.rs2_addr  = r.rs2;
				rec.rs1_rdata = src_value(r.rs1) ^ {31'h0, r.bad_rs};
				rec.rs2_rdata = src_value(r.rs2);
				rec.rd_addr   = r.rd;
				rec.rd_wdata  = (r.rd != 5'd0) ? $urandom : (r.x0_bad ? ($urandom | 32'h1) : 32'h0);
				@(posedge clk);
				retire <= rec;
				m_pc  = rec.pc_wdata;
				m_ord = rec.order + 1;
				if (!r.trap && r.rd != 5'd0) begin    // traps leave the shadow alone
					m_reg[r.rd]   = rec.rd_wdata;
					m_known[r.rd] = 1'b1;
				end
				e_retired++;
				if (r.flags != 4'h0) begin
					if (!e_caught)
						e_first = rec.order;              // first flagged record
					e_caught = 1'b1;
					e_errors++;                           // once per record
				end
				e_status = e_status | r.flags;
			end
		end
		@(posedge clk);
		retire <= '0;
		repeat (3) @(posedge clk);      // let the results reach the log
	endtask

	task automatic end_test(input int num, input string name);
		tests++;
		errs += test_errs;
		if (test_errs != 0)
			tests_failed++;
		$display("test %0d %s: %s", num, name, (test_errs == 0) ? "passed" : "failed");
		test_errs = 0;
	endtask

	task automatic clear_model();
		e_status  = 4'h0;
		e_retired = 0;
		e_errors  = 0;
		e_first   = 32'h0;
		e_caught  = 1'b0;
	endtask

	initial begin
		logic [31:0] d;
		void'($urandom(32'h7eb7eb5a));
		reset        = 1'b1;
		retire       = '0;
		axil_req     = '0;
		errs         = 0;
		test_errs    = 0;
		tests        = 0;
		tests_failed = 0;
		m_pc         = 32'h0000_1000;
		m_ord        = 32'h0;
		foreach (m_known[i])
			m_known[i] = 1'b0;
		clear_model();
		// grp pc_jmp ord_skip halt trap rs1 rs2 bad_rs rd x0_bad flags
		add_row(1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 1, 0, 0, 2, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 1, 2, 0, 3, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 3, 2, 0, 4, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 4, 1, 0, 5, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 5, 3, 0, 6, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 6, 4, 0, 7, 0, 4'h0);
		add_row(1, 0, 0, 0, 0, 7, 5, 0, 1, 0, 4'h0);
		add_row(2, 1, 0, 0, 0, 1, 2, 0, 8, 0, 4'h1);      // pc jump
		add_row(2, 0, 0, 1, 0, 0, 0, 0, 9, 0, 4'h0);      // halt
		add_row(2, 1, 1, 0, 0, 8, 9, 0, 10, 0, 4'h0);     // new baseline
		add_row(3, 0, 1, 0, 0, 2, 3, 0, 11, 0, 4'h2);     // order skip
		add_row(4, 0, 0, 0, 0, 3, 4, 1, 12, 0, 4'h4);     // stale rs1
		add_row(4, 0, 0, 0, 0, 20, 21, 0, 13, 0, 4'h0);   // never written
		add_row(4, 0, 0, 0, 1, 1, 0, 0, 2, 0, 4'h0);      // trap writes x2
		add_row(4, 0, 0, 0, 0, 2, 0, 0, 14, 0, 4'h0);
		add_row(5, 0, 0, 0, 0, 5, 6, 0, 0, 1, 4'h8);      // x0 write
		add_row(5, 1, 0, 0, 0, 4, 7, 1, 15, 0, 4'h5);     // two flags, one error
		add_row(6, 0, 0, 0, 0, 14, 15, 0, 16, 0, 4'h0);
		add_row(6, 0, 0, 0, 0, 16, 3, 0, 17, 0, 4'h0);
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		check_regs();
		axi_read(`REG_CTRL, 0, d);
		check_eq(d, 32'h0, "ctrl readback");
		axi_read(5'h14, 0, d);                            // unmapped offset
		check_eq(d, 32'h0, "unmapped readback");
		apply_group(1);
		check_regs();
		end_test(1, "reset and clean run");
		apply_group(2);
		check_regs();
		end_test(2, "pc break and halt");
		apply_group(3);
		check_regs();
		end_test(3, "order skip");
		apply_group(4);
		check_regs();
		end_test(4, "register checks");
		apply_group(5);
		check_regs();
		end_test(5, "x0 write and double error");
		axi_write(`REG_CTRL, 32'h1);
		clear_model();
		check_regs();
		apply_group(6);
		axi_read(`REG_RETIRED, 4, d);                     // master stalls 4 cycles
		check_eq(d, e_retired, "retired after stall");
		end_test(6, "clear and held read");

		if (dut0.sva0.fails != 0) begin
			$display("%0d assertion failures", dut0.sva0.fails);
			errs += dut0.sva0.fails;
		end
		$display("tests %0d, failed %0d, mismatches %0d", tests, tests_failed, errs);
		if (errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
rvfi_mon_pkg.sv
rvfi_pc_check.sv
rvfi_reg_check.sv
rvfi_err_log.sv
rvfi_axil_regs.sv
rvfi_mon_top.sv
rvfi_mon_sva.sv
rvfi_mon_tb.sv
